// File: rtl/cakeGeomPkg.sv
package cakeGeomPkg;

	// screen column as reported by the pixel scanner
	typedef logic [9:0] pixelX_t;

	// screen row as reported by the pixel scanner
	typedef logic [9:0] pixelY_t;

	// top edge of a cake
	// the playfield is 480 rows tall so nine bits cover it
	typedef logic [8:0] cakeY_t;

	// cakes are square
	localparam int unsigned CakeSize = 20;

	// falling cakes leave here and come back at the top
	localparam cakeY_t ScreenBottom = 9'd480;

	// rising cakes leave here and come back at the bottom
	localparam cakeY_t ScreenTop = 9'd0;

endpackage

// File: rtl/cakeLanePkg.sv
package cakeLanePkg;

	import cakeGeomPkg::*;

	// four trucks throw cakes in this field
	localparam int NumLanes = 4;
	localparam int CakesPerLane = 6;
	localparam int NumCakes = NumLanes * CakesPerLane;

	// one bit per cake
	// bit lane * CakesPerLane + cake
	typedef logic [NumCakes-1:0] hitMask_t;

	// everything that makes one lane different from another
	typedef struct packed {
		pixelX_t laneX;
		logic fallsDown;
		logic [1:0] speed;
		cakeY_t [0:CakesPerLane-1] startY;
	} laneCfg_t;

	// lanes from left to right
	localparam laneCfg_t LaneTable [NumLanes] = '{
		'{
			laneX: 10'd65,
			fallsDown: 1'b1,
			speed: 2'd1,
			startY: '{9'd70, 9'd150, 9'd200, 9'd290, 9'd370, 9'd450}
		},
		'{
			laneX: 10'd100,
			fallsDown: 1'b0,
			speed: 2'd1,
			startY: '{9'd50, 9'd150, 9'd220, 9'd290, 9'd340, 9'd440}
		},
		// the fast lane
		'{
			laneX: 10'd240,
			fallsDown: 1'b0,
			speed: 2'd2,
			startY: '{9'd25, 9'd75, 9'd180, 9'd210, 9'd350, 9'd375}
		},
		'{
			laneX: 10'd510,
			fallsDown: 1'b1,
			speed: 2'd1,
			startY: '{9'd20, 9'd100, 9'd200, 9'd255, 9'd330, 9'd400}
		}
	};

endpackage

// File: rtl/cakeLane.sv
module cakeLane
	import cakeGeomPkg::*;
	import cakeLanePkg::*;
#(
	parameter bit FallsDown = 1'b1,
	parameter logic [1:0] Speed = 2'd1,
	parameter cakeY_t [0:CakesPerLane-1] StartY = '0
)(
	input logic update,
	input logic rst,
	input logic step,
	output cakeY_t [0:CakesPerLane-1] cakeY
);

	localparam int IdxW = $clog2(CakesPerLane);

	// the value a wrapping cake jumps to
	localparam cakeY_t ReentryY = FallsDown ? ScreenTop : ScreenBottom;

	logic [CakesPerLane-1:0] atEdge;
	logic wrapAny;
	logic [IdxW-1:0] wrapIdx;

	// which cakes have run off their edge
	always_comb
	begin
		for (int i = 0; i < CakesPerLane; i++)
		begin
			if (FallsDown)
				atEdge[i] = (cakeY[i] >= ScreenBottom);
			else
				atEdge[i] = (cakeY[i] == ScreenTop);
		end
	end

	// first cake in lane order wins
	// the loop runs backwards so the lowest index is written last
	always_comb
	begin
		wrapAny = 1'b0;
		wrapIdx = '0;
		for (int i = CakesPerLane - 1; i >= 0; i--)
		begin
			if (atEdge[i])
			begin
				wrapAny = 1'b1;
				wrapIdx = IdxW'(i);
			end
		end
	end

	always_ff @(posedge update)
	begin
		if (rst)
			cakeY <= StartY;
		else if (step)
		begin
			if (wrapAny)
			begin
				// the whole lane stands still while one cake wraps
				cakeY[wrapIdx] <= ReentryY;
			end
			else
			begin
				for (int i = 0; i < CakesPerLane; i++)
				begin
					if (FallsDown)
						cakeY[i] <= cakeY[i] + cakeY_t'(Speed);
					else
						cakeY[i] <= cakeY[i] - cakeY_t'(Speed);
				end
			end
		end
	end

endmodule

// File: rtl/pixelQueryFifo.sv
module pixelQueryFifo
	import cakeGeomPkg::*;
#(
	// power of two, at least 2
	parameter int QueryDepth = 4
)(
	input logic update,
	input logic rst,
	input logic pixelReq,
	input pixelX_t pixelX,
	input pixelY_t pixelY,
	output logic pixelAck,
	output logic qValid,
	output pixelX_t qX,
	output pixelY_t qY,
	input logic qPop
);

	localparam int PtrW = $clog2(QueryDepth);

	pixelX_t memX [QueryDepth];
	pixelY_t memY [QueryDepth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;

	logic full;
	logic push;
	logic pop;

	assign full = (count == (PtrW + 1)'(QueryDepth));
	assign qValid = (count != '0);

	// a request is taken once while ack is still low
	// and only when there is room for it
	assign push = pixelReq && !pixelAck && !full;
	assign pop = qPop && qValid;

	// head of the queue
	assign qX = memX[rdPtr];
	assign qY = memY[rdPtr];

	// intake side of the four-phase handshake
	// pixelAck also remembers that the current request is already stored
	always_ff @(posedge update)
	begin
		if (rst)
			pixelAck <= 1'b0;
		else if (push)
			pixelAck <= 1'b1;
		else if (!pixelReq)
			pixelAck <= 1'b0;
	end

	always_ff @(posedge update)
	begin
		if (push)
		begin
			memX[wrPtr] <= pixelX;
			memY[wrPtr] <= pixelY;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge update)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + PtrW'(1);
			if (pop)
				rdPtr <= rdPtr + PtrW'(1);
		end
	end

	// occupancy
	always_ff @(posedge update)
	begin
		if (rst)
			count <= '0;
		else
		begin
			case ({push, pop})
				2'b10: count <= count + (PtrW + 1)'(1);
				2'b01: count <= count - (PtrW + 1)'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rtl/cakeHitTester.sv
module cakeHitTester
	import cakeGeomPkg::*;
	import cakeLanePkg::*;
(
	input logic update,
	input logic rst,
	input logic qValid,
	input pixelX_t qX,
	input pixelY_t qY,
	output logic qPop,
	input cakeY_t [0:NumLanes-1][0:CakesPerLane-1] laneY,
	output logic hitReq,
	output hitMask_t hitMask,
	input logic hitAck
);

	typedef enum logic [1:0] {
		stIdle,
		stHeld,
		stAckDrop
	} testState_t;

	testState_t state;
	hitMask_t hitNow;

	// strictly between lo and lo + CakeSize
	// one extra bit keeps the upper bound from wrapping
	function automatic logic insideSpan(input logic [9:0] pos, input logic [9:0] lo);
		logic [10:0] hi;
		hi = {1'b0, lo} + 11'(CakeSize);
		insideSpan = (pos > lo) && ({1'b0, pos} < hi);
	endfunction

	// test the head query against every cake at once
	always_comb
	begin
		for (int l = 0; l < NumLanes; l++)
		begin
			for (int c = 0; c < CakesPerLane; c++)
			begin
				hitNow[l * CakesPerLane + c] = insideSpan(qX, LaneTable[l].laneX)
					&& insideSpan(qY, {1'b0, laneY[l][c]});
			end
		end
	end

	// idle pops one query and tests it in the pop cycle
	// then the result waits for a full four-phase ack
	always_ff @(posedge update)
	begin
		if (rst)
		begin
			state <= stIdle;
			qPop <= 1'b0;
			hitReq <= 1'b0;
			hitMask <= '0;
		end
		else
		begin
			qPop <= 1'b0;
			case (state)
				stIdle:
				begin
					if (qPop)
					begin
						// heights of this very cycle go into the result
						hitMask <= hitNow;
						hitReq <= 1'b1;
						state <= stHeld;
					end
					else if (qValid)
						qPop <= 1'b1;
				end
				stHeld:
				begin
					if (hitAck)
					begin
						hitReq <= 1'b0;
						state <= stAckDrop;
					end
				end
				stAckDrop:
				begin
					// no new pop until the consumer lets go of ack
					if (!hitAck)
						state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: rtl/cakeField.sv
module cakeField
	import cakeGeomPkg::*;
	import cakeLanePkg::*;
#(
	parameter int QueryDepth = 4
)(
	input logic update,
	input logic rst,
	input logic step,
	input logic pixelReq,
	input pixelX_t pixelX,
	input pixelY_t pixelY,
	output logic pixelAck,
	output logic hitReq,
	output hitMask_t hitMask,
	input logic hitAck
);

	// every lane's six heights side by side
	cakeY_t [0:NumLanes-1][0:CakesPerLane-1] laneY;

	// queue head toward the tester
	logic qValid;
	pixelX_t qX;
	pixelY_t qY;
	logic qPop;

	// one mover per truck
	for (genvar g = 0; g < NumLanes; g++)
	begin : gLane
		cakeLane #(
			.FallsDown(LaneTable[g].fallsDown),
			.Speed(LaneTable[g].speed),
			.StartY(LaneTable[g].startY)
		) lane (
			.update(update),
			.rst(rst),
			.step(step),
			.cakeY(laneY[g])
		);
	end

	pixelQueryFifo #(
		.QueryDepth(QueryDepth)
	) queryFifo (
		.update(update),
		.rst(rst),
		.pixelReq(pixelReq),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelAck(pixelAck),
		.qValid(qValid),
		.qX(qX),
		.qY(qY),
		.qPop(qPop)
	);

	cakeHitTester hitTester (
		.update(update),
		.rst(rst),
		.qValid(qValid),
		.qX(qX),
		.qY(qY),
		.qPop(qPop),
		.laneY(laneY),
		.hitReq(hitReq),
		.hitMask(hitMask),
		.hitAck(hitAck)
	);

endmodule

// File: dv/cakeFieldTb.sv
module cakeFieldTb
	import cakeGeomPkg::*;
	import cakeLanePkg::*;
();

	localparam int WaitLimit = 200;
	localparam int HoldCycles = 20;

	logic update;
	logic rst;
	logic step;
	logic pixelReq;
	pixelX_t pixelX;
	pixelY_t pixelY;
	logic pixelAck;
	logic hitReq;
	hitMask_t hitMask;
	logic hitAck;

	// results still owed by the DUT, oldest first
	hitMask_t expMask [$];
	string expName [$];

	cakeField #(
		.QueryDepth(4)
	) dut0 (
		.update(update),
		.rst(rst),
		.step(step),
		.pixelReq(pixelReq),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelAck(pixelAck),
		.hitReq(hitReq),
		.hitMask(hitMask),
		.hitAck(hitAck)
	);

	initial
	begin
		update = 1'b0;
		forever #2 update = ~update;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkHitMask(input string name, input hitMask_t exp, input hitMask_t act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkLevel(input string name, input logic exp, input logic act);
		if (act !== exp)
			abortRun($sformatf("FAIL %s expected %b actual %b", name, exp, act));
	endtask

	task automatic nextCycle();
		@(posedge update);
		#1;
	endtask

	task automatic waitPixelAck(input logic level);
		int cycles;
		cycles = 0;
		while (pixelAck !== level)
		begin
			if (cycles == WaitLimit)
				abortRun($sformatf("pixelAck never went to %b in %0d cycles", level, WaitLimit));
			nextCycle();
			cycles++;
		end
	endtask

	task automatic waitHitReq(input logic level);
		int cycles;
		cycles = 0;
		while (hitReq !== level)
		begin
			if (cycles == WaitLimit)
				abortRun($sformatf("hitReq never went to %b in %0d cycles", level, WaitLimit));
			nextCycle();
			cycles++;
		end
	endtask

	// handshake outputs must come out of reset low
	task automatic applyReset();
		rst = 1'b1;
		step = 1'b0;
		pixelReq = 1'b0;
		hitAck = 1'b0;
		repeat (16) @(posedge update);
		#1;
		rst = 1'b0;
		checkLevel("pixelAck after reset", 1'b0, pixelAck);
		checkLevel("hitReq after reset", 1'b0, hitReq);
		checkHitMask("hitMask after reset", '0, hitMask);
	endtask

	task automatic applySteps(input int count);
		repeat (count)
		begin
			step = 1'b1;
			nextCycle();
		end
		step = 1'b0;
		nextCycle();
	endtask

	task automatic sendQuery(input pixelX_t x, input pixelY_t y);
		pixelX = x;
		pixelY = y;
		pixelReq = 1'b1;
		waitPixelAck(1'b1);
		pixelReq = 1'b0;
		waitPixelAck(1'b0);
	endtask

	// ack one result with a random delay and check it
	task automatic collectResult();
		hitMask_t exp;
		string name;
		int delay;
		if (expMask.size() == 0)
			abortRun("a result was collected although none was outstanding");
		exp = expMask.pop_front();
		name = expName.pop_front();
		waitHitReq(1'b1);
		checkHitMask(name, exp, hitMask);
		delay = $urandom % 6;
		repeat (delay) nextCycle();
		hitAck = 1'b1;
		waitHitReq(1'b0);
		hitAck = 1'b0;
		nextCycle();
	endtask

	task automatic drainResults();
		while (expMask.size() != 0)
			collectResult();
	endtask

	// tester and FIFO are both full, so intake has to stall
	// until one result is taken
	task automatic sendBlockedQuery(input pixelX_t x, input pixelY_t y);
		pixelX = x;
		pixelY = y;
		pixelReq = 1'b1;
		repeat (HoldCycles)
		begin
			nextCycle();
			checkLevel("pixelAck under back-pressure", 1'b0, pixelAck);
		end
		collectResult();
		waitPixelAck(1'b1);
		pixelReq = 1'b0;
		waitPixelAck(1'b0);
	endtask

	initial
	begin
		int fd;
		int x;
		int y;
		int count;
		int fields;
		string line;
		string cmd;
		string name;
		hitMask_t mask;
		void'($urandom(32'h8f7));
		step = 1'b0;
		pixelReq = 1'b0;
		pixelX = '0;
		pixelY = '0;
		hitAck = 1'b0;
		rst = 1'b1;
		applyReset();
		fd = $fopen("dv/cakeFieldStim.txt", "r");
		if (fd == 0)
			abortRun("could not open the stimulus file dv/cakeFieldStim.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			void'($sscanf(line, "%s", cmd));
			if (cmd == "S")
			begin
				void'($sscanf(line, "%s %d", cmd, count));
				applySteps(count);
			end
			else if (cmd == "D")
				drainResults();
			else if (cmd == "R")
			begin
				if (expMask.size() != 0)
					abortRun("reset requested with results still outstanding");
				applyReset();
			end
			else if (cmd == "Q" || cmd == "P" || cmd == "B")
			begin
				fields = $sscanf(line, "%s %d %d %s %h", cmd, x, y, name, mask);
				if (fields != 5)
					abortRun($sformatf("malformed query line in stimulus: %s", line));
				expMask.push_back(mask);
				expName.push_back(name);
				if (cmd == "B")
					sendBlockedQuery(pixelX_t'(x), pixelY_t'(y));
				else
					sendQuery(pixelX_t'(x), pixelY_t'(y));
				// Q waits for its own answer before the next line
				if (cmd == "Q")
					drainResults();
			end
			else
				abortRun($sformatf("unknown stimulus command %s", cmd));
		end
		$fclose(fd);
		if (expMask.size() != 0)
			abortRun("stimulus ended with results still outstanding");
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: dv/cakeFieldStim.txt
# S count | R | D (drain results) | Q/P/B x y name mask (wait, no wait, blocked)
# x and y decimal, mask hex with bit lane*6+cake
Q 75 80 resetLane0Cake0 000001
Q 65 80 leftEdgeExcluded 000000
S 10
Q 250 10 fastLaneAfter10 001000
Q 75 85 lane0After10 000001
S 20
Q 75 490 lane0AtBottom 000020
Q 110 30 lane1NearTop 000040
S 1
Q 75 5 lane0Wrapped 000020
Q 75 101 lane0Frozen 000001
Q 110 20 lane1Moved 000040
Q 520 70 lane3Moved 040000
P 75 5 bpFirst 000020
P 110 20 bpSecond 000040
P 520 70 bpThird 040000
P 250 20 bpFourth 002000
P 75 101 bpFifth 000001
B 110 120 bpBlocked 000080
D
Q 300 100 laneGap 000000
R
Q 75 80 afterMidReset 000001
Q 65 80 afterMidResetEdge 000000

// File: files.f
rtl/cakeGeomPkg.sv
rtl/cakeLanePkg.sv
rtl/cakeLane.sv
rtl/pixelQueryFifo.sv
rtl/cakeHitTester.sv
rtl/cakeField.sv
dv/cakeFieldTb.sv

// File: Bender.yml
package:
  name: cake_field

sources:
  - rtl/cakeGeomPkg.sv
  - rtl/cakeLanePkg.sv
  - rtl/cakeLane.sv
  - rtl/pixelQueryFifo.sv
  - rtl/cakeHitTester.sv
  - rtl/cakeField.sv
  - target: test
    files:
      - dv/cakeFieldTb.sv
